/* fp_format_pkg.sv */
`default_nettype none

package fp_format_pkg;

  //////////////////////////////
  // ieee single precision layout
  //////////////////////////////
  localparam int FLEN       = 32;
  localparam int EXPO_WIDTH = 8;
  localparam int FRAC_WIDTH = 23;
  localparam int BIAS       = 127;

  typedef logic [FLEN-1:0]       fp_word_t;  // whole operand or result
  typedef logic [EXPO_WIDTH-1:0] expo_t;     // biased exponent field
  typedef logic [FRAC_WIDTH-1:0] frac_t;     // fraction without hidden bit

  // quiet nan with zero payload
  localparam fp_word_t CANONICAL_NAN = 32'h7fc0_0000;

endpackage

`default_nettype wire

/* sqrt_unit_pkg.sv */
`default_nettype none

package sqrt_unit_pkg;

  typedef logic [3:0] id_t;           // instruction tag
  typedef logic [2:0] rm_t;           // riscv rounding mode
  typedef logic [4:0] fflags_t;       // nv dz of uf nx
  typedef logic [2:0] grs_t;          // guard round sticky
  typedef logic [3:0] special_case_t; // inf snan qnan zero

  // rounding mode encodings
  localparam rm_t RM_RNE = 3'd0;
  localparam rm_t RM_RTZ = 3'd1;
  localparam rm_t RM_RDN = 3'd2;
  localparam rm_t RM_RUP = 3'd3;
  localparam rm_t RM_RMM = 3'd4;

  //////////////////////////////
  // mantissa core fsm
  //////////////////////////////
  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    FINISH
  } sqrt_state_t;

endpackage

`default_nettype wire

/* fp_classify.sv */
`default_nettype none

module fp_classify #(
  parameter bit ENABLE_SUBNORMAL = 1'b1
) (
  input  fp_format_pkg::fp_word_t       rs1,
  output logic                          hidden_bit,
  output sqrt_unit_pkg::special_case_t  special_case
);
  import fp_format_pkg::*;

  expo_t expo;
  frac_t frac;
  logic  expo_all_ones;
  logic  expo_zero;
  logic  frac_zero;
  logic  is_inf;
  logic  is_snan;
  logic  is_qnan;
  logic  is_zero;

  assign expo = rs1[FLEN-2 -: EXPO_WIDTH];
  assign frac = rs1[FRAC_WIDTH-1:0];

  assign expo_all_ones = &expo;
  assign expo_zero     = ~|expo;
  assign frac_zero     = ~|frac;

  assign hidden_bit = ~expo_zero;

  assign is_inf  = expo_all_ones & frac_zero;
  assign is_snan = expo_all_ones & ~frac_zero & ~frac[FRAC_WIDTH-1]; // quiet bit clear
  assign is_qnan = expo_all_ones & frac[FRAC_WIDTH-1];
  // subnormals flush to zero when not supported
  assign is_zero = expo_zero & (frac_zero | ~ENABLE_SUBNORMAL);

  assign special_case = {is_inf, is_snan, is_qnan, is_zero};

endmodule

`default_nettype wire

/* pre_normalize.sv */
`default_nettype none

module pre_normalize (
  input  fp_format_pkg::frac_t                   frac_in,
  input  logic                                   hidden_bit,
  output fp_format_pkg::expo_t                   left_shift_amt,
  output logic [fp_format_pkg::FRAC_WIDTH:0]     frac_normalized
);
  import fp_format_pkg::*;

  expo_t leading_zeros;

  // leading zero count, highest set bit wins
  always_comb begin
    leading_zeros = expo_t'(FRAC_WIDTH); // all zero fraction
    for (int i = 0; i < FRAC_WIDTH; i++) begin
      if (frac_in[i]) begin
        leading_zeros = expo_t'(FRAC_WIDTH - 1 - i);
      end
    end
  end

  // one extra position moves the leading one into the hidden slot
  always_comb begin
    if (hidden_bit) begin
      left_shift_amt = '0;
    end else begin
      left_shift_amt = leading_zeros + expo_t'(1);
    end
  end

  assign frac_normalized = {hidden_bit, frac_in} << left_shift_amt;

endmodule

`default_nettype wire

/* sqrt_mantissa.sv */
`default_nettype none

module sqrt_mantissa #(
  parameter int ITERATION = 27
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic [ITERATION-1:0] radicand,
  output logic                 done,
  output logic [ITERATION-1:0] root,
  output logic                 remainder_nonzero
);
  import sqrt_unit_pkg::*;

  localparam int CNT_W = $clog2(ITERATION);
  localparam int REM_W = ITERATION + 2;

  sqrt_state_t        state;
  logic [CNT_W-1:0]   count;
  logic [2*ITERATION-1:0] rad_sr;  // radicand followed by zero pairs
  logic [REM_W-1:0]   rem;
  logic [REM_W+1:0]   rem_shifted;
  logic [REM_W+1:0]   trial;
  logic               trial_fits;
  logic               load;

  assign load = (state == IDLE) & start;

  //////////////////////////////
  // one digit per clock
  //////////////////////////////
  assign rem_shifted = {rem, rad_sr[2*ITERATION-1 -: 2]}; // bring down two bits
  assign trial       = {2'b00, root, 2'b01};               // 4*root + 1
  assign trial_fits  = rem_shifted >= trial;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            state <= BUSY;
            count <= '0;
          end
        end
        BUSY: begin
          if (count == CNT_W'(ITERATION - 1)) begin
            state <= FINISH;
            done  <= 1'b1; // last root bit lands this edge
          end else begin
            count <= count + CNT_W'(1);
          end
        end
        FINISH: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // datapath, held after the last step until the next start
  always_ff @(posedge clk) begin
    if (load) begin
      rad_sr <= {radicand, {ITERATION{1'b0}}};
      rem    <= '0;
      root   <= '0;
    end else if (state == BUSY) begin
      rad_sr <= rad_sr << 2;
      root   <= {root[ITERATION-2:0], trial_fits};
      if (trial_fits) begin
        rem <= REM_W'(rem_shifted - trial);
      end else begin
        rem <= REM_W'(rem_shifted); // restore
      end
    end
  end

  assign remainder_nonzero = |rem;

endmodule

`default_nettype wire

/* fp_sqrt.sv */
`default_nettype none

module fp_sqrt #(
  parameter bit ENABLE_SUBNORMAL = 1'b1
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               issue_request,
  output logic                               issue_ready,
  input  sqrt_unit_pkg::id_t                 issue_id,
  input  fp_format_pkg::fp_word_t            rs1,
  input  logic                               rs1_hidden_bit,
  input  sqrt_unit_pkg::special_case_t       rs1_special_case,
  input  sqrt_unit_pkg::rm_t                 rm_in,
  output logic                               wb_done,
  input  logic                               wb_ack,
  output sqrt_unit_pkg::id_t                 wb_id,
  output logic                               result_sign,
  output fp_format_pkg::expo_t               result_expo,
  output logic [fp_format_pkg::FRAC_WIDTH:0] result_frac,
  output sqrt_unit_pkg::grs_t                grs,
  output logic                               early_terminate,
  output fp_format_pkg::fp_word_t            early_result,
  output logic                               invalid,
  output sqrt_unit_pkg::rm_t                 rm_out
);
  import fp_format_pkg::*;
  import sqrt_unit_pkg::*;

  localparam int ITERATION = FRAC_WIDTH + 4;

  //////////////////////////////
  // pre-normalization
  //////////////////////////////
  expo_t               left_shift_amt;
  logic [FRAC_WIDTH:0] frac_normalized;
  logic [EXPO_WIDTH:0] expo_normalized; // msb is the borrow

  pre_normalize pre_normalize_i (
    .frac_in         (rs1[FRAC_WIDTH-1:0]),
    .hidden_bit      (rs1_hidden_bit),
    .left_shift_amt  (left_shift_amt),
    .frac_normalized (frac_normalized)
  );

  // subnormal exponent reads as 1, minus the shift
  assign expo_normalized = {1'b0, rs1[FLEN-2 -: EXPO_WIDTH]}
                         + {{EXPO_WIDTH{1'b0}}, ~rs1_hidden_bit}
                         - (ENABLE_SUBNORMAL ? {1'b0, left_shift_amt} : '0);

  //////////////////////////////
  // one entry input buffer
  //////////////////////////////
  logic                buf_valid;
  logic                buf_sign;
  logic [EXPO_WIDTH:0] buf_expo;
  logic [FRAC_WIDTH:0] buf_mant;
  id_t                 buf_id;
  rm_t                 buf_rm;
  special_case_t       buf_special;
  logic                push;
  logic                pop;
  logic                ack;
  logic                in_progress;

  assign ack         = wb_ack & wb_done;
  assign push        = issue_request & issue_ready;
  assign pop         = buf_valid & (~in_progress | ack); // refill on the ack edge
  assign issue_ready = ~buf_valid | pop;

  always_ff @(posedge clk) begin
    if (rst) begin
      buf_valid <= 1'b0;
    end else begin
      buf_valid <= push | (buf_valid & ~pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      buf_sign    <= rs1[FLEN-1];
      buf_expo    <= expo_normalized;
      buf_mant    <= frac_normalized;
      buf_id      <= issue_id;
      buf_rm      <= rm_in;
      buf_special <= rs1_special_case;
    end
  end

  //////////////////////////////
  // core launch
  //////////////////////////////
  logic                 odd_exponent;
  logic [ITERATION-1:0] radicand;
  logic [ITERATION-1:0] root;
  logic                 core_done;
  logic                 remainder_nonzero;

  assign odd_exponent = ~buf_expo[0]; // bias is odd
  assign radicand     = odd_exponent ? {buf_mant, 3'b000} : {1'b0, buf_mant, 2'b00};

  sqrt_mantissa #(
    .ITERATION (ITERATION)
  ) sqrt_mantissa_i (
    .clk               (clk),
    .rst               (rst),
    .start             (pop),
    .radicand          (radicand),
    .done              (core_done),
    .root              (root),
    .remainder_nonzero (remainder_nonzero)
  );

  // operation in flight, until its result is acknowledged
  always_ff @(posedge clk) begin
    if (rst) begin
      in_progress <= 1'b0;
    end else begin
      in_progress <= pop | (in_progress & ~ack);
    end
  end

  logic                op_sign;
  logic [EXPO_WIDTH:0] op_expo;
  logic                op_is_one;
  special_case_t       op_special;

  always_ff @(posedge clk) begin
    if (pop) begin
      op_sign    <= buf_sign;
      op_expo    <= buf_expo;
      op_is_one  <= ~buf_sign & (buf_expo == (EXPO_WIDTH+1)'(BIAS))
                  & (buf_mant == {1'b1, {FRAC_WIDTH{1'b0}}});
      op_special <= buf_special;
      wb_id      <= buf_id;
      rm_out     <= buf_rm;
    end
  end

  //////////////////////////////
  // exponent path
  //////////////////////////////
  logic signed [EXPO_WIDTH:0] unbiased_expo;
  logic signed [EXPO_WIDTH:0] half_expo;

  assign unbiased_expo = $signed(op_expo) - $signed((EXPO_WIDTH+1)'(BIAS));
  assign half_expo     = unbiased_expo >>> 1; // toward minus infinity
  assign result_expo   = half_expo[EXPO_WIDTH-1:0] + expo_t'(BIAS);

  //////////////////////////////
  // special operands
  //////////////////////////////
  logic is_inf;
  logic is_snan;
  logic is_qnan;
  logic is_zero;
  logic output_nan;
  logic output_inf;

  assign {is_inf, is_snan, is_qnan, is_zero} = op_special;

  assign invalid         = is_snan | (op_sign & ~is_zero & ~is_qnan);
  assign output_nan      = is_snan | is_qnan | invalid;
  assign output_inf      = is_inf & ~op_sign;
  assign early_terminate = output_nan | output_inf | is_zero | op_is_one;

  always_comb begin
    if (output_nan) begin
      early_result = CANONICAL_NAN;
    end else if (output_inf) begin
      early_result = {1'b0, {EXPO_WIDTH{1'b1}}, frac_t'(0)};
    end else if (is_zero) begin
      early_result = {op_sign, {(FLEN-1){1'b0}}}; // keeps the sign of zero
    end else begin
      early_result = {1'b0, expo_t'(BIAS), frac_t'(0)};
    end
  end

  //////////////////////////////
  // writeback hold
  //////////////////////////////
  assign result_sign = op_sign;
  assign result_frac = root[ITERATION-1 -: FRAC_WIDTH+1];
  assign grs         = {root[2], root[1], root[0] | remainder_nonzero};

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_done <= 1'b0;
    end else if (ack) begin
      wb_done <= 1'b0;
    end else if (core_done) begin
      wb_done <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* fp_round.sv */
`default_nettype none

module fp_round (
  input  logic                               result_sign,
  input  fp_format_pkg::expo_t               result_expo,
  input  logic [fp_format_pkg::FRAC_WIDTH:0] result_frac,
  input  sqrt_unit_pkg::grs_t                grs,
  input  logic                               early_terminate,
  input  fp_format_pkg::fp_word_t            early_result,
  input  logic                               invalid,
  input  sqrt_unit_pkg::rm_t                 rm,
  output fp_format_pkg::fp_word_t            result,
  output sqrt_unit_pkg::fflags_t             fflags
);
  import fp_format_pkg::*;
  import sqrt_unit_pkg::*;

  logic                  inexact;
  logic                  lsb;
  logic                  round_up;
  logic [FRAC_WIDTH+1:0] mant_sum;     // extra bit catches the carry
  expo_t                 expo_rounded;

  assign inexact = |grs;
  assign lsb     = result_frac[0];

  always_comb begin
    case (rm)
      RM_RNE:  round_up = grs[2] & (lsb | grs[1] | grs[0]); // ties to even
      RM_RTZ:  round_up = 1'b0;
      RM_RDN:  round_up = result_sign & inexact;
      RM_RUP:  round_up = ~result_sign & inexact;
      RM_RMM:  round_up = grs[2];
      default: round_up = 1'b0;
    endcase
  end

  assign mant_sum     = {1'b0, result_frac} + {{(FRAC_WIDTH+1){1'b0}}, round_up};
  // mantissa overflow bumps the exponent, fraction is already zero
  assign expo_rounded = result_expo + {{(EXPO_WIDTH-1){1'b0}}, mant_sum[FRAC_WIDTH+1]};

  always_comb begin
    if (early_terminate) begin
      result = early_result;
    end else begin
      result = {result_sign, expo_rounded, mant_sum[FRAC_WIDTH-1:0]};
    end
  end

  assign fflags = {invalid, 3'b000, inexact & ~early_terminate};

endmodule

`default_nettype wire

/* fp_sqrt_top.sv */
`default_nettype none

module fp_sqrt_top #(
  parameter bit ENABLE_SUBNORMAL = 1'b1
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    issue_request,
  output logic                    issue_ready,
  input  sqrt_unit_pkg::id_t      issue_id,
  input  fp_format_pkg::fp_word_t issue_rs1,
  input  sqrt_unit_pkg::rm_t      issue_rm,
  output logic                    wb_done,
  input  logic                    wb_ack,
  output sqrt_unit_pkg::id_t      wb_id,
  output fp_format_pkg::fp_word_t wb_result,
  output sqrt_unit_pkg::fflags_t  wb_fflags
);
  import fp_format_pkg::*;
  import sqrt_unit_pkg::*;

  logic                rs1_hidden_bit;
  special_case_t       rs1_special_case;
  logic                result_sign;
  expo_t               result_expo;
  logic [FRAC_WIDTH:0] result_frac;
  grs_t                grs;
  logic                early_terminate;
  fp_word_t            early_result;
  logic                invalid;
  rm_t                 rm;

  fp_classify #(
    .ENABLE_SUBNORMAL (ENABLE_SUBNORMAL)
  ) fp_classify_i (
    .rs1          (issue_rs1),
    .hidden_bit   (rs1_hidden_bit),
    .special_case (rs1_special_case)
  );

  fp_sqrt #(
    .ENABLE_SUBNORMAL (ENABLE_SUBNORMAL)
  ) fp_sqrt_i (
    .clk              (clk),
    .rst              (rst),
    .issue_request    (issue_request),
    .issue_ready      (issue_ready),
    .issue_id         (issue_id),
    .rs1              (issue_rs1),
    .rs1_hidden_bit   (rs1_hidden_bit),
    .rs1_special_case (rs1_special_case),
    .rm_in            (issue_rm),
    .wb_done          (wb_done),
    .wb_ack           (wb_ack),
    .wb_id            (wb_id),
    .result_sign      (result_sign),
    .result_expo      (result_expo),
    .result_frac      (result_frac),
    .grs              (grs),
    .early_terminate  (early_terminate),
    .early_result     (early_result),
    .invalid          (invalid),
    .rm_out           (rm)
  );

  fp_round fp_round_i (
    .result_sign     (result_sign),
    .result_expo     (result_expo),
    .result_frac     (result_frac),
    .grs             (grs),
    .early_terminate (early_terminate),
    .early_result    (early_result),
    .invalid         (invalid),
    .rm              (rm),
    .result          (wb_result),
    .fflags          (wb_fflags)
  );

endmodule

`default_nettype wire

/* tb_fp_sqrt.sv */
`default_nettype none

module tb_fp_sqrt;
  import fp_format_pkg::*;
  import sqrt_unit_pkg::*;

  logic     clk;
  logic     rst;
  logic     issue_request;
  logic     issue_ready;
  id_t      issue_id;
  fp_word_t issue_rs1;
  rm_t      issue_rm;
  logic     wb_done;
  logic     wb_ack;
  id_t      wb_id;
  fp_word_t wb_result;
  fflags_t  wb_fflags;

  int            seed = 32'hb246;
  int            ack_max;
  int            ack_wait;
  int            n_issued;
  int            n_checked;
  int            cycle_count;
  logic [40:0]   exp_q[$];  // id, flags, result
  event          ack_driven;

  fp_sqrt_top dut_i (
    .clk           (clk),
    .rst           (rst),
    .issue_request (issue_request),
    .issue_ready   (issue_ready),
    .issue_id      (issue_id),
    .issue_rs1     (issue_rs1),
    .issue_rm      (issue_rm),
    .wb_done       (wb_done),
    .wb_ack        (wb_ack),
    .wb_id         (wb_id),
    .wb_result     (wb_result),
    .wb_fflags     (wb_fflags)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    report_failure($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  //////////////////////////////
  // expected ieee square root
  //////////////////////////////
  function automatic logic [36:0] ref_sqrt(input logic [31:0] a, input logic [2:0] rm);
    logic             sign;
    logic [7:0]       ex;
    logic [22:0]      fr;
    int               e;
    longint unsigned  m;
    longint unsigned  n;
    longint unsigned  r;
    logic             g;
    logic             s;
    logic             up;
    logic [24:0]      mant;
    logic [7:0]       rexp;
    sign = a[31];
    ex   = a[30:23];
    fr   = a[22:0];
    if (ex == 8'hff && fr != 23'd0) begin
      return {fr[22] ? 5'b00000 : 5'b10000, 32'h7fc0_0000};
    end
    if (ex == 8'h00 && fr == 23'd0) return {5'b00000, a}; // signed zero
    if (sign) return {5'b10000, 32'h7fc0_0000};
    if (ex == 8'hff) return {5'b00000, 32'h7f80_0000};
    if (ex != 8'h00) begin
      m = {40'd0, 1'b1, fr};
      e = int'(ex) - 127;
    end else begin
      m = {40'd0, 1'b0, fr};
      e = -126;
      while (m[23] == 1'b0) begin
        m = m << 1;
        e = e - 1;
      end
    end
    if (e % 2 != 0) begin // even exponent for halving
      m = m << 1;
      e = e - 1;
    end
    n = m << 25;
    r = longint'($sqrt(real'(n)));
    while (r * r > n) r = r - 1;
    while ((r + 1) * (r + 1) <= n) r = r + 1;
    g = r[0];
    s = (r * r != n);
    case (rm)
      3'd0:    up = g & (r[1] | s);
      3'd3:    up = g | s;
      3'd4:    up = g;
      default: up = 1'b0; // rtz, rdn on a positive root
    endcase
    mant = {1'b0, r[24:1]} + {24'd0, up};
    rexp = 8'(e / 2 + 127);
    if (mant[24]) begin
      rexp = rexp + 8'd1;
      mant = mant >> 1;
    end
    return {4'b0000, g | s, 1'b0, rexp, mant[22:0]};
  endfunction

  function automatic logic [31:0] int_to_fp(input int v);
    logic [23:0] b;
    logic [23:0] t;
    int          p;
    b = 24'(v);
    p = 0;
    for (int i = 0; i < 24; i++) begin
      if (b[i]) p = i;
    end
    t = b << (23 - p);
    return {1'b0, 8'(127 + p), t[22:0]};
  endfunction

  task automatic issue_op(input logic [31:0] a, input logic [2:0] rm);
    logic [36:0] e;
    e = ref_sqrt(a, rm);
    while (!issue_ready) @(ack_driven);
    issue_request = 1'b1;
    issue_rs1     = a;
    issue_rm      = rm;
    issue_id      = 4'(n_issued);
    exp_q.push_back({4'(n_issued), e});
    n_issued      = n_issued + 1;
    @(posedge clk); // accepting edge
    @(ack_driven);
    issue_request = 1'b0;
  endtask

  task automatic drain;
    while (exp_q.size() != 0) @(ack_driven);
  endtask

  //////////////////////////////
  // ack, compare, monitors
  //////////////////////////////
  initial begin
    forever begin
      @(negedge clk);
      wb_ack = 1'b0;
      if (!rst && wb_done) begin
        if (ack_wait == 0) begin
          wb_ack   = 1'b1;
          ack_wait = (ack_max == 0) ? 0 : int'({$random(seed)} % (ack_max + 1));
        end else begin
          ack_wait = ack_wait - 1;
        end
      end
      -> ack_driven;
    end
  end

  // sampled on the rising edge, after the falling edge drive has settled
  always @(posedge clk) begin
    logic [40:0] e;
    // ready low only with one op in flight and one buffered
    if (!rst && !issue_ready) begin
      assert (exp_q.size() == 2) else report_failure("issue_ready low without a full pipeline");
    end
    if (wb_done && wb_ack) begin
      assert (exp_q.size() != 0) else report_failure("result arrived with nothing outstanding");
      e = exp_q.pop_front();
      assert (wb_id == e[40:37]) else value_mismatch("wb_id", 32'(wb_id), 32'(e[40:37]));
      assert (wb_result == e[31:0]) else value_mismatch("wb_result", wb_result, e[31:0]);
      assert (wb_fflags == e[36:32])
        else value_mismatch("wb_fflags", 32'(wb_fflags), 32'(e[36:32]));
      n_checked = n_checked + 1;
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > 200 + 40 * n_issued) report_failure("timeout, results stopped arriving");
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////
  initial begin
    logic [31:0] specials[8];
    logic [31:0] a;
    int          n;
    rst = 1'b1;
    issue_request = 1'b0;
    issue_id = '0;
    issue_rs1 = '0;
    issue_rm = '0;
    wb_ack = 1'b0;
    ack_max = 0;
    ack_wait = 0;
    n_issued = 0;
    n_checked = 0;
    cycle_count = 0;
    specials = '{32'h0000_0000, 32'h8000_0000, 32'h7f80_0000, 32'hff80_0000,
                 32'hc040_0000, 32'h7fc0_0000, 32'h7f80_0001, 32'h3f80_0000};
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(ack_driven);
    assert (!wb_done) else value_mismatch("wb_done", 32'(wb_done), 32'd0);
    assert (issue_ready) else value_mismatch("issue_ready", 32'(issue_ready), 32'd1);

    for (int m = 0; m < 5; m++) begin
      foreach (specials[i]) issue_op(specials[i], 3'(m));
    end

    for (int i = 0; i < 300; i++) begin // positive normals, rne
      a = {1'b0, 8'(1 + {$random(seed)} % 254), 23'($random(seed))};
      issue_op(a, 3'd0);
    end
    for (int k = 1; k < 4096; k += 205) begin
      assert (ref_sqrt(int_to_fp(k * k), 3'd0) == {5'd0, int_to_fp(k)})
        else report_failure("reference root of a perfect square is not exact");
      issue_op(int_to_fp(k * k), 3'd0); // exact root, nx clear
    end

    for (int i = 0; i < 200; i++) issue_op($random(seed), 3'(i % 5));

    issue_op(32'h0000_0001, 3'd0);
    issue_op(32'h007f_ffff, 3'd0);
    for (int i = 0; i < 30; i++) begin
      a = {1'(i % 4 == 3), 8'h00, 23'($random(seed)) | 23'd1};
      issue_op(a, 3'(i % 5));
    end

    ack_max = 5;
    for (int i = 0; i < 60; i++) begin
      a = {1'b0, 8'(1 + {$random(seed)} % 254), 23'($random(seed))};
      issue_op(a, 3'({$random(seed)} % 5));
    end
    drain();

    ack_max = 0;
    ack_wait = 0;
    issue_op(32'h4049_0fdb, 3'd0);
    n = 0; // rising edges since the accepting edge
    while (!wb_done && n < 100) begin
      @(ack_driven);
      n = n + 1;
    end
    assert (n == 29) else value_mismatch("latency", 32'(n), 32'd29);
    drain();

    if (n_checked != n_issued) begin
      report_failure("not every issued operation returned a result");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* filelist.f */
fp_format_pkg.sv
sqrt_unit_pkg.sv
fp_classify.sv
pre_normalize.sv
sqrt_mantissa.sv
fp_sqrt.sv
fp_round.sv
fp_sqrt_top.sv
tb_fp_sqrt.sv

/* run_sim.sh */
#!/bin/sh
# build and run the square root testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_fp_sqrt -o sim_fp_sqrt
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_fp_sqrt)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
  exit 0
fi
exit 1
